/* adam_pkg.sv */
package adam_pkg;

    // host command opcodes
    typedef enum logic [1:0] {
        OP_PAUSE,
        OP_RESUME,
        OP_RESET,
        OP_STATUS
    } op_e;

    typedef enum logic {
        RESP_OK,
        RESP_BAD_UNIT
    } resp_e;

    // domain select values on cmd_dom and rsp_dom
    localparam logic DOM_LS = 1'b0;
    localparam logic DOM_HS = 1'b1;

    localparam int UNIT_W = 3;
    localparam int TAG_W  = 4;

    // width of the paused bitmap in a response
    localparam int MAX_UNITS = 4;

    localparam int LS_UNITS = 2;
    localparam int HS_UNITS = 4;

    // length of a unit reset pulse in cycles
    localparam int RST_CYCLES = 4;

endpackage

/* adam_cmd_route.sv */
`timescale 1ns/1ns

module adam_cmd_route (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  logic                        cmd_dom,
    input  adam_pkg::op_e               cmd_op,
    input  logic [adam_pkg::UNIT_W-1:0] cmd_unit,
    input  logic [adam_pkg::TAG_W-1:0]  cmd_tag,

    output logic                        ls_cmd_valid,
    input  logic                        ls_cmd_ready,
    output adam_pkg::op_e               ls_cmd_op,
    output logic [adam_pkg::UNIT_W-1:0] ls_cmd_unit,
    output logic [adam_pkg::TAG_W-1:0]  ls_cmd_tag,

    output logic                        hs_cmd_valid,
    input  logic                        hs_cmd_ready,
    output adam_pkg::op_e               hs_cmd_op,
    output logic [adam_pkg::UNIT_W-1:0] hs_cmd_unit,
    output logic [adam_pkg::TAG_W-1:0]  hs_cmd_tag
);

    logic [1:0]                  slot_valid;
    logic [1:0]                  slot_ready;
    logic [1:0]                  slot_load;
    adam_pkg::op_e               slot_op   [2];
    logic [adam_pkg::UNIT_W-1:0] slot_unit [2];
    logic [adam_pkg::TAG_W-1:0]  slot_tag  [2];

    assign slot_ready[adam_pkg::DOM_LS] = ls_cmd_ready;
    assign slot_ready[adam_pkg::DOM_HS] = hs_cmd_ready;

    // addressed slot is empty or drains this cycle
    assign cmd_ready = !slot_valid[cmd_dom] || slot_ready[cmd_dom];

    for (genvar d = 0; d < 2; d++) begin : g_slot
        assign slot_load[d] = cmd_valid && cmd_ready && (cmd_dom == 1'(d));

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                slot_valid[d] <= 1'b0;
            end else if (slot_load[d]) begin
                slot_valid[d] <= 1'b1;
            end else if (slot_ready[d]) begin
                slot_valid[d] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (slot_load[d]) begin
                slot_op[d]   <= cmd_op;
                slot_unit[d] <= cmd_unit;
                slot_tag[d]  <= cmd_tag;
            end
        end
    end

    assign ls_cmd_valid = slot_valid[adam_pkg::DOM_LS];
    assign ls_cmd_op    = slot_op[adam_pkg::DOM_LS];
    assign ls_cmd_unit  = slot_unit[adam_pkg::DOM_LS];
    assign ls_cmd_tag   = slot_tag[adam_pkg::DOM_LS];

    assign hs_cmd_valid = slot_valid[adam_pkg::DOM_HS];
    assign hs_cmd_op    = slot_op[adam_pkg::DOM_HS];
    assign hs_cmd_unit  = slot_unit[adam_pkg::DOM_HS];
    assign hs_cmd_tag   = slot_tag[adam_pkg::DOM_HS];

endmodule

/* adam_unit_seq.sv */
`timescale 1ns/1ns

module adam_unit_seq #(
    parameter int NO_UNITS = 2
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  adam_pkg::op_e                  cmd_op,
    input  logic [adam_pkg::UNIT_W-1:0]    cmd_unit,
    input  logic [adam_pkg::TAG_W-1:0]     cmd_tag,

    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output adam_pkg::resp_e                rsp_status,
    output logic [adam_pkg::TAG_W-1:0]     rsp_tag,
    output logic [adam_pkg::MAX_UNITS-1:0] rsp_paused,

    output logic [NO_UNITS-1:0]            unit_pause,
    output logic [NO_UNITS-1:0]            unit_rst,
    input  logic [NO_UNITS-1:0]            unit_pause_ack
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        RESET,
        RESPOND
    } state_e;

    state_e                                    state;
    logic [NO_UNITS-1:0]                       pause_q;
    logic [NO_UNITS-1:0]                       rst_q;
    logic [$clog2(adam_pkg::RST_CYCLES+1)-1:0] cnt;

    // one-hot unit of the command being worked on
    logic [NO_UNITS-1:0]        sel_q;
    logic [adam_pkg::TAG_W-1:0] tag_q;
    adam_pkg::resp_e            status_q;

    logic [NO_UNITS-1:0] cmd_sel;
    logic [NO_UNITS-1:0] pause_next;
    logic                settled;
    logic                ack_match;

    // decode the unit index, all zero when out of range
    always_comb begin
        cmd_sel = '0;
        for (int i = 0; i < NO_UNITS; i++) begin
            cmd_sel[i] = (int'(cmd_unit) == i);
        end
        if (cmd_op == adam_pkg::OP_PAUSE) begin
            pause_next = pause_q | cmd_sel;
        end else begin
            pause_next = pause_q & ~cmd_sel;
        end
    end

    // pause bit already at target and ack agrees
    assign settled = (((pause_next ^ pause_q) | (pause_next ^ unit_pause_ack)) & cmd_sel) == '0;
    assign ack_match = ((pause_q ^ unit_pause_ack) & sel_q) == '0;

    assign cmd_ready = (state == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            pause_q <= '0;
            rst_q   <= '0;
            cnt     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        cnt <= '0;
                        if (cmd_sel == '0) begin
                            state <= RESPOND;
                        end else begin
                            case (cmd_op)
                                adam_pkg::OP_PAUSE, adam_pkg::OP_RESUME: begin
                                    pause_q <= pause_next;
                                    state   <= settled ? RESPOND : WAIT_ACK;
                                end
                                adam_pkg::OP_RESET: begin
                                    rst_q <= cmd_sel;
                                    state <= RESET;
                                end
                                default: begin
                                    state <= RESPOND;
                                end
                            endcase
                        end
                    end
                end
                WAIT_ACK: begin
                    if (ack_match) begin
                        state <= RESPOND;
                    end
                end
                RESET: begin
                    // rst drops after RST_CYCLES, response one cycle later
                    cnt <= cnt + 1'b1;
                    if (int'(cnt) == adam_pkg::RST_CYCLES - 1) begin
                        rst_q <= '0;
                    end
                    if (int'(cnt) == adam_pkg::RST_CYCLES) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            sel_q <= cmd_sel;
            tag_q <= cmd_tag;
            if (cmd_sel == '0) begin
                status_q <= adam_pkg::RESP_BAD_UNIT;
            end else begin
                status_q <= adam_pkg::RESP_OK;
            end
        end
    end

    assign unit_pause = pause_q;
    assign unit_rst   = rst_q;

    assign rsp_valid  = (state == RESPOND);
    assign rsp_status = status_q;
    assign rsp_tag    = tag_q;

    // upper bitmap bits read as zero
    always_comb begin
        rsp_paused                 = '0;
        rsp_paused[NO_UNITS-1:0]   = pause_q;
    end

endmodule

/* adam_resp_merge.sv */
`timescale 1ns/1ns

module adam_resp_merge (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           ls_rsp_valid,
    output logic                           ls_rsp_ready,
    input  adam_pkg::resp_e                ls_rsp_status,
    input  logic [adam_pkg::TAG_W-1:0]     ls_rsp_tag,
    input  logic [adam_pkg::MAX_UNITS-1:0] ls_rsp_paused,

    input  logic                           hs_rsp_valid,
    output logic                           hs_rsp_ready,
    input  adam_pkg::resp_e                hs_rsp_status,
    input  logic [adam_pkg::TAG_W-1:0]     hs_rsp_tag,
    input  logic [adam_pkg::MAX_UNITS-1:0] hs_rsp_paused,

    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic                           rsp_dom,
    output adam_pkg::resp_e                rsp_status,
    output logic [adam_pkg::TAG_W-1:0]     rsp_tag,
    output logic [adam_pkg::MAX_UNITS-1:0] rsp_paused
);

    logic can_take;
    logic gnt_ls;
    logic gnt_hs;
    // set when hsdom wins the next tie
    logic pri_hs;

    assign can_take = !rsp_valid || rsp_ready;

    assign gnt_ls = can_take && ls_rsp_valid && (!hs_rsp_valid || !pri_hs);
    assign gnt_hs = can_take && hs_rsp_valid && (!ls_rsp_valid || pri_hs);

    assign ls_rsp_ready = gnt_ls;
    assign hs_rsp_ready = gnt_hs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            pri_hs    <= 1'b0;
        end else begin
            if (gnt_ls || gnt_hs) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
            // hand priority to the other side
            if (gnt_ls) begin
                pri_hs <= 1'b1;
            end else if (gnt_hs) begin
                pri_hs <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_ls) begin
            rsp_dom    <= adam_pkg::DOM_LS;
            rsp_status <= ls_rsp_status;
            rsp_tag    <= ls_rsp_tag;
            rsp_paused <= ls_rsp_paused;
        end else if (gnt_hs) begin
            rsp_dom    <= adam_pkg::DOM_HS;
            rsp_status <= hs_rsp_status;
            rsp_tag    <= hs_rsp_tag;
            rsp_paused <= hs_rsp_paused;
        end
    end

endmodule

/* adam_sysctl.sv */
`timescale 1ns/1ns

module adam_sysctl (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           cmd_valid,
    output logic                           cmd_ready,
    input  logic                           cmd_dom,
    input  adam_pkg::op_e                  cmd_op,
    input  logic [adam_pkg::UNIT_W-1:0]    cmd_unit,
    input  logic [adam_pkg::TAG_W-1:0]     cmd_tag,

    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic                           rsp_dom,
    output adam_pkg::resp_e                rsp_status,
    output logic [adam_pkg::TAG_W-1:0]     rsp_tag,
    output logic [adam_pkg::MAX_UNITS-1:0] rsp_paused,

    output logic [adam_pkg::LS_UNITS-1:0]  ls_pause,
    output logic [adam_pkg::LS_UNITS-1:0]  ls_rst,
    input  logic [adam_pkg::LS_UNITS-1:0]  ls_pause_ack,

    output logic [adam_pkg::HS_UNITS-1:0]  hs_pause,
    output logic [adam_pkg::HS_UNITS-1:0]  hs_rst,
    input  logic [adam_pkg::HS_UNITS-1:0]  hs_pause_ack
);

    // router to sequencers
    logic                        ls_cmd_valid;
    logic                        ls_cmd_ready;
    adam_pkg::op_e               ls_cmd_op;
    logic [adam_pkg::UNIT_W-1:0] ls_cmd_unit;
    logic [adam_pkg::TAG_W-1:0]  ls_cmd_tag;

    logic                        hs_cmd_valid;
    logic                        hs_cmd_ready;
    adam_pkg::op_e               hs_cmd_op;
    logic [adam_pkg::UNIT_W-1:0] hs_cmd_unit;
    logic [adam_pkg::TAG_W-1:0]  hs_cmd_tag;

    // sequencers to merger
    logic                           ls_rsp_valid;
    logic                           ls_rsp_ready;
    adam_pkg::resp_e                ls_rsp_status;
    logic [adam_pkg::TAG_W-1:0]     ls_rsp_tag;
    logic [adam_pkg::MAX_UNITS-1:0] ls_rsp_paused;

    logic                           hs_rsp_valid;
    logic                           hs_rsp_ready;
    adam_pkg::resp_e                hs_rsp_status;
    logic [adam_pkg::TAG_W-1:0]     hs_rsp_tag;
    logic [adam_pkg::MAX_UNITS-1:0] hs_rsp_paused;

    adam_cmd_route i_cmd_route (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_dom      (cmd_dom),
        .cmd_op       (cmd_op),
        .cmd_unit     (cmd_unit),
        .cmd_tag      (cmd_tag),
        .ls_cmd_valid (ls_cmd_valid),
        .ls_cmd_ready (ls_cmd_ready),
        .ls_cmd_op    (ls_cmd_op),
        .ls_cmd_unit  (ls_cmd_unit),
        .ls_cmd_tag   (ls_cmd_tag),
        .hs_cmd_valid (hs_cmd_valid),
        .hs_cmd_ready (hs_cmd_ready),
        .hs_cmd_op    (hs_cmd_op),
        .hs_cmd_unit  (hs_cmd_unit),
        .hs_cmd_tag   (hs_cmd_tag)
    );

    adam_unit_seq #(
        .NO_UNITS (adam_pkg::LS_UNITS)
    ) lsdom_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_valid      (ls_cmd_valid),
        .cmd_ready      (ls_cmd_ready),
        .cmd_op         (ls_cmd_op),
        .cmd_unit       (ls_cmd_unit),
        .cmd_tag        (ls_cmd_tag),
        .rsp_valid      (ls_rsp_valid),
        .rsp_ready      (ls_rsp_ready),
        .rsp_status     (ls_rsp_status),
        .rsp_tag        (ls_rsp_tag),
        .rsp_paused     (ls_rsp_paused),
        .unit_pause     (ls_pause),
        .unit_rst       (ls_rst),
        .unit_pause_ack (ls_pause_ack)
    );

    adam_unit_seq #(
        .NO_UNITS (adam_pkg::HS_UNITS)
    ) hsdom_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_valid      (hs_cmd_valid),
        .cmd_ready      (hs_cmd_ready),
        .cmd_op         (hs_cmd_op),
        .cmd_unit       (hs_cmd_unit),
        .cmd_tag        (hs_cmd_tag),
        .rsp_valid      (hs_rsp_valid),
        .rsp_ready      (hs_rsp_ready),
        .rsp_status     (hs_rsp_status),
        .rsp_tag        (hs_rsp_tag),
        .rsp_paused     (hs_rsp_paused),
        .unit_pause     (hs_pause),
        .unit_rst       (hs_rst),
        .unit_pause_ack (hs_pause_ack)
    );

    adam_resp_merge i_resp_merge (
        .clk           (clk),
        .rst_n         (rst_n),
        .ls_rsp_valid  (ls_rsp_valid),
        .ls_rsp_ready  (ls_rsp_ready),
        .ls_rsp_status (ls_rsp_status),
        .ls_rsp_tag    (ls_rsp_tag),
        .ls_rsp_paused (ls_rsp_paused),
        .hs_rsp_valid  (hs_rsp_valid),
        .hs_rsp_ready  (hs_rsp_ready),
        .hs_rsp_status (hs_rsp_status),
        .hs_rsp_tag    (hs_rsp_tag),
        .hs_rsp_paused (hs_rsp_paused),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_dom       (rsp_dom),
        .rsp_status    (rsp_status),
        .rsp_tag       (rsp_tag),
        .rsp_paused    (rsp_paused)
    );

endmodule

/* adam_sysctl_checker.sv */
`timescale 1ns/1ns

module adam_sysctl_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    input  logic                           cmd_ready,
    input  logic                           cmd_dom,
    input  adam_pkg::op_e                  cmd_op,
    input  logic [adam_pkg::UNIT_W-1:0]    cmd_unit,
    input  logic [adam_pkg::TAG_W-1:0]     cmd_tag,
    input  logic                           rsp_valid,
    input  logic                           rsp_ready,
    input  logic                           rsp_dom,
    input  adam_pkg::resp_e                rsp_status,
    input  logic [adam_pkg::TAG_W-1:0]     rsp_tag,
    input  logic [adam_pkg::MAX_UNITS-1:0] rsp_paused,
    input  logic [adam_pkg::LS_UNITS-1:0]  ls_pause,
    input  logic [adam_pkg::LS_UNITS-1:0]  ls_rst,
    input  logic [adam_pkg::LS_UNITS-1:0]  ls_pause_ack,
    input  logic [adam_pkg::HS_UNITS-1:0]  hs_pause,
    input  logic [adam_pkg::HS_UNITS-1:0]  hs_rst,
    input  logic [adam_pkg::HS_UNITS-1:0]  hs_pause_ack,
    output int                             err_count,
    output int                             outstanding
);

    localparam int ALL_UNITS = adam_pkg::LS_UNITS + adam_pkg::HS_UNITS;

    // queued commands as {op, unit, tag} with the oldest first per domain
    logic [8:0]                     pend [2][$];
    logic [adam_pkg::MAX_UNITS-1:0] model [2];
    logic [ALL_UNITS-1:0]           pause_all;
    logic [ALL_UNITS-1:0]           rst_all;
    logic [ALL_UNITS-1:0]           ack_all;
    int                             run [ALL_UNITS];
    int                             pulses [ALL_UNITS];
    int                             resets_in [ALL_UNITS];
    int                             resets_out [ALL_UNITS];
    logic                           in_reset = 1'b1;
    logic                           fresh = 1'b1;
    logic                           stall = 1'b0;
    logic [9:0]                     held;
    int                             errs = 0;
    int                             open_cmds = 0;

    assign pause_all   = {hs_pause, ls_pause};
    assign rst_all     = {hs_rst, ls_rst};
    assign ack_all     = {hs_pause_ack, ls_pause_ack};
    assign err_count   = errs;
    assign outstanding = open_cmds;

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("ERR time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
        errs++;
    endtask

    task automatic complain(input string msg);
        $display("time=%0t %s", $time, msg);
        errs++;
    endtask

    function automatic int unit_count(input logic dom);
        return (dom == adam_pkg::DOM_HS) ? adam_pkg::HS_UNITS : adam_pkg::LS_UNITS;
    endfunction

    // global unit number with lsdom units first
    function automatic int global_unit(input logic dom, input int u);
        return ((dom == adam_pkg::DOM_HS) ? adam_pkg::LS_UNITS : 0) + u;
    endfunction

    // port name of one unit line from its global unit number
    function automatic string line_name(input string sig, input int g);
        if (g < adam_pkg::LS_UNITS) begin
            return $sformatf("ls_%s[%0d]", sig, g);
        end
        return $sformatf("hs_%s[%0d]", sig, g - adam_pkg::LS_UNITS);
    endfunction

    // bitmap after one command with bad units left out
    function automatic logic [adam_pkg::MAX_UNITS-1:0] apply_cmd(
        input logic [adam_pkg::MAX_UNITS-1:0] bm, input logic [8:0] c, input logic dom);
        int u;
        u = int'(c[6:4]);
        if (u < unit_count(dom)) begin
            if (c[8:7] == adam_pkg::OP_PAUSE) begin
                bm[u] = 1'b1;
            end else if (c[8:7] == adam_pkg::OP_RESUME) begin
                bm[u] = 1'b0;
            end
        end
        return bm;
    endfunction

    always @(posedge clk) begin : watch
        logic [8:0]                     head;
        logic [adam_pkg::MAX_UNITS-1:0] lines;
        logic [adam_pkg::MAX_UNITS-1:0] m1;
        logic [adam_pkg::MAX_UNITS-1:0] m2;
        adam_pkg::resp_e                exp_status;
        int                             u;
        int                             g;
        if (!rst_n) begin
            in_reset = 1'b1;
            fresh = 1'b1;
            stall = 1'b0;
            for (int d = 0; d < 2; d++) begin
                pend[d].delete();
                model[d] = '0;
            end
            for (int i = 0; i < ALL_UNITS; i++) begin
                run[i] = 0;
                pulses[i] = 0;
                resets_in[i] = 0;
                resets_out[i] = 0;
            end
        end else begin
            if (in_reset) begin
                if ({pause_all, rst_all} !== '0) begin
                    complain("pause or rst line not low after reset");
                end
                if (rsp_valid !== 1'b0) begin
                    complain("rsp_valid not low after reset");
                end
                if (cmd_ready !== 1'b1) begin
                    complain("cmd_ready not high after reset");
                end
                in_reset = 1'b0;
            end
            // rst pulse length and no pulse without a reset command
            for (int i = 0; i < ALL_UNITS; i++) begin
                if (rst_all[i]) begin
                    run[i]++;
                end else if (run[i] != 0) begin
                    if (run[i] != adam_pkg::RST_CYCLES) begin
                        mismatch({line_name("rst", i), " pulse length"},
                                 32'(adam_pkg::RST_CYCLES), 32'(run[i]));
                    end
                    pulses[i]++;
                    if (pulses[i] > resets_in[i]) begin
                        complain("rst pulse without a reset command");
                    end
                    run[i] = 0;
                end
            end
            // pause lines may run at most two queued commands ahead of the model
            for (int d = 0; d < 2; d++) begin
                lines = (d == 1) ? hs_pause : {2'b00, ls_pause};
                m1 = model[d];
                m2 = model[d];
                if (pend[d].size() > 0) begin
                    m1 = apply_cmd(model[d], pend[d][0], d[0]);
                end
                if (pend[d].size() > 1) begin
                    m2 = apply_cmd(m1, pend[d][1], d[0]);
                end
                if (lines != model[d] && lines != m1 && lines != m2) begin
                    mismatch((d == 1) ? "hs_pause" : "ls_pause", 32'(m1), 32'(lines));
                end
            end
            if (stall) begin
                if (!rsp_valid) begin
                    complain("response withdrawn while rsp_ready was low");
                end else if ({rsp_dom, rsp_status, rsp_tag, rsp_paused} != held) begin
                    mismatch("rsp fields", 32'(held),
                             32'({rsp_dom, rsp_status, rsp_tag, rsp_paused}));
                end
            end
            stall = rsp_valid && !rsp_ready;
            held = {rsp_dom, rsp_status, rsp_tag, rsp_paused};
            if (rsp_valid && pend[rsp_dom].size() == 0) begin
                if (fresh) begin
                    complain("response with no outstanding command in its domain");
                end
            end else if (rsp_valid) begin
                head = pend[rsp_dom][0];
                u = int'(head[6:4]);
                g = global_unit(rsp_dom, u);
                if (fresh) begin
                    exp_status = (u < unit_count(rsp_dom)) ? adam_pkg::RESP_OK
                                                            : adam_pkg::RESP_BAD_UNIT;
                    if (rsp_tag != head[3:0]) begin
                        mismatch("rsp_tag", 32'(head[3:0]), 32'(rsp_tag));
                    end
                    if (rsp_status != exp_status) begin
                        mismatch("rsp_status", 32'(exp_status), 32'(rsp_status));
                    end
                    m1 = apply_cmd(model[rsp_dom], head, rsp_dom);
                    if (rsp_paused != m1) begin
                        mismatch("rsp_paused", 32'(m1), 32'(rsp_paused));
                    end
                    if (exp_status == adam_pkg::RESP_OK &&
                        head[8:7] != adam_pkg::OP_STATUS) begin
                        if (head[8:7] == adam_pkg::OP_RESET) begin
                            if (pulses[g] <= resets_out[g]) begin
                                complain("reset response before rst pulse");
                            end
                        end else if (ack_all[g] != (head[8:7] == adam_pkg::OP_PAUSE)) begin
                            mismatch(line_name("pause_ack", g),
                                     32'(head[8:7] == adam_pkg::OP_PAUSE), 32'(ack_all[g]));
                        end
                    end
                end
                if (rsp_ready) begin
                    model[rsp_dom] = apply_cmd(model[rsp_dom], head, rsp_dom);
                    if (head[8:7] == adam_pkg::OP_RESET && u < unit_count(rsp_dom)) begin
                        resets_out[g]++;
                    end
                    void'(pend[rsp_dom].pop_front());
                end
            end
            fresh = !rsp_valid || rsp_ready;
            if (cmd_valid && cmd_ready) begin
                pend[cmd_dom].push_back({cmd_op, cmd_unit, cmd_tag});
                u = int'(cmd_unit);
                if (cmd_op == adam_pkg::OP_RESET && u < unit_count(cmd_dom)) begin
                    resets_in[global_unit(cmd_dom, u)]++;
                end
                // slot, sequencer and merger register hold three at most
                if (pend[cmd_dom].size() > 3) begin
                    complain("command accepted while its domain was full");
                end
            end
            open_cmds = pend[0].size() + pend[1].size();
        end
    end

endmodule

/* tb_adam_sysctl.sv */
`timescale 1ns/1ns

module tb_adam_sysctl;

    localparam int N_CMDS     = 400;
    localparam int MAX_CYCLES = N_CMDS * 40;
    localparam int ALL_UNITS  = adam_pkg::LS_UNITS + adam_pkg::HS_UNITS;

    logic                           clk;
    logic                           rst_n;
    logic                           cmd_valid;
    logic                           cmd_ready;
    logic                           cmd_dom;
    adam_pkg::op_e                  cmd_op;
    logic [adam_pkg::UNIT_W-1:0]    cmd_unit;
    logic [adam_pkg::TAG_W-1:0]     cmd_tag;
    logic                           rsp_valid;
    logic                           rsp_ready;
    logic                           rsp_dom;
    adam_pkg::resp_e                rsp_status;
    logic [adam_pkg::TAG_W-1:0]     rsp_tag;
    logic [adam_pkg::MAX_UNITS-1:0] rsp_paused;
    logic [adam_pkg::LS_UNITS-1:0]  ls_pause;
    logic [adam_pkg::LS_UNITS-1:0]  ls_rst;
    logic [adam_pkg::LS_UNITS-1:0]  ls_pause_ack;
    logic [adam_pkg::HS_UNITS-1:0]  hs_pause;
    logic [adam_pkg::HS_UNITS-1:0]  hs_rst;
    logic [adam_pkg::HS_UNITS-1:0]  hs_pause_ack;

    // unit model state with lsdom units in the low bits
    logic [ALL_UNITS-1:0] acks;
    logic [ALL_UNITS-1:0] pauses;
    int                   wait_cnt [ALL_UNITS];

    int seed;
    int sent = 0;
    int cycles = 0;
    int timeouts = 0;
    int err_count;
    int outstanding;

    assign pauses       = {hs_pause, ls_pause};
    assign ls_pause_ack = acks[adam_pkg::LS_UNITS-1:0];
    assign hs_pause_ack = acks[ALL_UNITS-1:adam_pkg::LS_UNITS];

    adam_sysctl i_adam_sysctl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_dom      (cmd_dom),
        .cmd_op       (cmd_op),
        .cmd_unit     (cmd_unit),
        .cmd_tag      (cmd_tag),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_dom      (rsp_dom),
        .rsp_status   (rsp_status),
        .rsp_tag      (rsp_tag),
        .rsp_paused   (rsp_paused),
        .ls_pause     (ls_pause),
        .ls_rst       (ls_rst),
        .ls_pause_ack (ls_pause_ack),
        .hs_pause     (hs_pause),
        .hs_rst       (hs_rst),
        .hs_pause_ack (hs_pause_ack)
    );

    adam_sysctl_checker i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_dom      (cmd_dom),
        .cmd_op       (cmd_op),
        .cmd_unit     (cmd_unit),
        .cmd_tag      (cmd_tag),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_dom      (rsp_dom),
        .rsp_status   (rsp_status),
        .rsp_tag      (rsp_tag),
        .rsp_paused   (rsp_paused),
        .ls_pause     (ls_pause),
        .ls_rst       (ls_rst),
        .ls_pause_ack (ls_pause_ack),
        .hs_pause     (hs_pause),
        .hs_rst       (hs_rst),
        .hs_pause_ack (hs_pause_ack),
        .err_count    (err_count),
        .outstanding  (outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_and_stop();
        @(negedge clk);
        $display("errors: %0d from checker, %0d timeout", err_count, timeouts);
        if (err_count + timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    // commands, rsp_ready and unit acks all draw from one process
    initial begin : drive
        logic [31:0] r;
        logic        taken;
        seed = 32'ha351891e;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd_dom = adam_pkg::DOM_LS;
        cmd_op = adam_pkg::OP_STATUS;
        cmd_unit = '0;
        cmd_tag = '0;
        rsp_ready = 1'b0;
        acks = '0;
        for (int i = 0; i < ALL_UNITS; i++) begin
            wait_cnt[i] = -1;
        end
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        forever begin
            @(posedge clk);
            taken = cmd_valid && cmd_ready;
            #2;
            if (taken) begin
                cmd_valid = 1'b0;
                sent++;
            end
            r = $random(seed);
            if (!cmd_valid && sent < N_CMDS && r[1:0] != 2'b00) begin
                cmd_valid = 1'b1;
                cmd_dom = r[2];
                cmd_op = adam_pkg::op_e'(r[4:3]);
                // unit 0 to 7 so that some are out of range
                cmd_unit = r[7:5];
                cmd_tag = r[11:8];
            end
            r = $random(seed);
            rsp_ready = (r[1:0] != 2'b00);
            // each ack follows its pause bit after 0 to 7 cycles
            for (int i = 0; i < ALL_UNITS; i++) begin
                if (acks[i] == pauses[i]) begin
                    wait_cnt[i] = -1;
                end else begin
                    if (wait_cnt[i] < 0) begin
                        r = $random(seed);
                        wait_cnt[i] = int'(r[2:0]);
                    end
                    if (wait_cnt[i] == 0) begin
                        acks[i] = pauses[i];
                    end else begin
                        wait_cnt[i]--;
                    end
                end
            end
        end
    end

    initial begin : run_end
        while (rst_n !== 1'b1 || sent < N_CMDS || outstanding != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        report_and_stop();
    end

    initial begin : watchdog
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run not finished after %0d cycles, %0d commands sent, %0d open",
                 cycles, sent, outstanding);
        timeouts = 1;
        report_and_stop();
    end

endmodule

/* sim.f */
adam_pkg.sv
adam_cmd_route.sv
adam_unit_seq.sv
adam_resp_merge.sv
adam_sysctl.sv
adam_sysctl_checker.sv
tb_adam_sysctl.sv

/* Makefile */
# Verilator build and run of the system-control testbench

VERILATOR ?= verilator
TOP       ?= tb_adam_sysctl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_LINE ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_LINE"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_LINE)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
